//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_line_draw
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= CHECKS FAILED
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build $(TOP) with Verilator, run it and scan $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "test failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "run ended early, see $(LOG)"; exit 1; fi
	@echo "test passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- compile.f
+incdir+tests
verilog/line_gfx_pkg.sv
verilog/line_engine.sv
verilog/pixel_fifo.sv
verilog/pixel_writer.sv
verilog/line_draw_top.sv
tests/tb_line_draw.sv

//--- tests/line_ref_model.svh
`ifndef LINE_REF_MODEL_SVH
`define LINE_REF_MODEL_SVH

// one row: endpoints, color, and whether both full flags get toggled
typedef struct packed {
  coord_t x0;
  coord_t y0;
  coord_t x1;
  coord_t y1;
  color_t color;
  logic   stall;
} line_case_t;

localparam int NUM_CASES = 8;

line_case_t line_cases [NUM_CASES];
pixel_t ref_pixels [$];
logic [15:0] lfsr_state = 16'd29156;

function automatic void load_cases();
  // shallow
  line_cases[0] = '{10'd10, 10'd20, 10'd45, 10'd31, 32'h00a1b2c3, 1'b0};
  // steep
  line_cases[1] = '{10'd100, 10'd50, 10'd110, 10'd90, 32'h00ff0000, 1'b0};
  // x0 above x1
  line_cases[2] = '{10'd700, 10'd300, 10'd640, 10'd280, 32'h0000ff00, 1'b0};
  // steep, drawn bottom to top with x stepping down
  line_cases[3] = '{10'd400, 10'd590, 10'd420, 10'd500, 32'h000000ff, 1'b0};
  line_cases[4] = '{10'd3, 10'd5, 10'd120, 10'd64, 32'h00123456, 1'b1};
  line_cases[5] = '{10'd799, 10'd599, 10'd760, 10'd450, 32'h00fedcba, 1'b1};
  // single point
  line_cases[6] = '{10'd333, 10'd222, 10'd333, 10'd222, 32'h00777777, 1'b0};
  // exact diagonal
  line_cases[7] = '{10'd50, 10'd50, 10'd80, 10'd20, 32'h00c0ffee, 1'b1};
endfunction

// 16-bit Fibonacci LFSR, taps 16 14 13 11, one step per bit
function automatic logic next_rand_bit();
  logic fb;
  fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
  lfsr_state = {lfsr_state[14:0], fb};
  return fb;
endfunction

function automatic int abs_diff(input int a, input int b);
  return (a > b) ? a - b : b - a;
endfunction

function automatic int ref_count(input line_case_t lc);
  int dx;
  int dy;
  dx = abs_diff(int'(lc.x0), int'(lc.x1));
  dy = abs_diff(int'(lc.y0), int'(lc.y1));
  return ((dx > dy) ? dx : dy) + 1;
endfunction

// Bresenham walk, major axis from its low end, ties count as shallow
function automatic void ref_line(input line_case_t lc);
  int a0, b0, a1, b1;
  int t;
  int dmaj;
  int dmin;
  int err;
  int b;
  logic steep;
  pixel_t p;
  steep = abs_diff(int'(lc.y0), int'(lc.y1)) > abs_diff(int'(lc.x0), int'(lc.x1));
  a0 = steep ? int'(lc.y0) : int'(lc.x0);
  b0 = steep ? int'(lc.x0) : int'(lc.y0);
  a1 = steep ? int'(lc.y1) : int'(lc.x1);
  b1 = steep ? int'(lc.x1) : int'(lc.y1);
  if (a0 > a1) begin
    t = a0;
    a0 = a1;
    a1 = t;
    t = b0;
    b0 = b1;
    b1 = t;
  end
  dmaj = a1 - a0;
  dmin = abs_diff(b0, b1);
  err = dmaj / 2;
  b = b0;
  ref_pixels.delete();
  for (int a = a0; a <= a1; a++) begin
    p.x = coord_t'(steep ? b : a);
    p.y = coord_t'(steep ? a : b);
    p.color = lc.color;
    ref_pixels.push_back(p);
    err -= dmin;
    if (err < 0) begin
      b += (b1 > b0) ? 1 : -1;
      err += dmaj;
    end
  end
endfunction

`endif

//--- tests/tb_line_draw.sv
`timescale 1ns/1ps

module tb_line_draw import line_gfx_pkg::*; ();

  localparam int FIFO_DEPTH = 4;
  localparam logic [FB_BASE_W-1:0] FB_BASE = 9'h041;
  localparam int HOLD_CYCLES = 3;

  logic clk = 1'b0;
  logic rst = 1'b1;
  line_cmd_t cmd = '0;
  logic cmd_valid = 1'b0;
  logic af_full = 1'b0;
  logic wdf_full = 1'b0;
  logic cmd_ready;
  logic [MEM_ADDR_W-1:0] af_addr_din;
  logic af_wr_en;
  logic [MEM_DATA_W-1:0] wdf_din;
  logic [MEM_MASK_W-1:0] wdf_mask_din;
  logic wdf_wr_en;

  logic stall_en = 1'b0;
  logic full_seen = 1'b0;
  int errors = 0;
  int checks = 0;
  int watchdog_cycles = 0;

  // writes in arrival order
  logic [MEM_ADDR_W-1:0] got_addr [$];
  logic [MEM_DATA_W-1:0] got_data [$];
  logic [MEM_MASK_W-1:0] got_mask [$];

  `include "line_ref_model.svh"

  always #4 clk = ~clk;

  line_draw_top #(
    .FIFO_DEPTH(FIFO_DEPTH),
    .FB_BASE   (FB_BASE)
  ) line_draw_top_inst (
    .clk         (clk),
    .rst         (rst),
    .cmd         (cmd),
    .cmd_valid   (cmd_valid),
    .cmd_ready   (cmd_ready),
    .af_full     (af_full),
    .wdf_full    (wdf_full),
    .af_addr_din (af_addr_din),
    .af_wr_en    (af_wr_en),
    .wdf_din     (wdf_din),
    .wdf_mask_din(wdf_mask_din),
    .wdf_wr_en   (wdf_wr_en)
  );

  task automatic check_addr(input string name, input logic [MEM_ADDR_W-1:0] got,
                            input logic [MEM_ADDR_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_data(input int idx, input logic [MEM_DATA_W-1:0] got_d,
                            input logic [MEM_DATA_W-1:0] exp_d,
                            input logic [MEM_MASK_W-1:0] got_m,
                            input logic [MEM_MASK_W-1:0] exp_m);
    checks += 2;
    if (got_d !== exp_d) begin
      $display("CHECK FAILED wdf_din[%0d] got %h expected %h", idx, got_d, exp_d);
      errors++;
    end
    if (got_m !== exp_m) begin
      $display("CHECK FAILED wdf_mask_din[%0d] got %h expected %h", idx, got_m, exp_m);
      errors++;
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    checks++;
    if (got != exp) begin
      $display("CHECK FAILED %s got %0h expected %0h", name, got, exp);
      errors++;
    end
  endtask

  // only the bytes of lane x mod 4 are written
  function automatic logic [MEM_MASK_W-1:0] lane_mask(input coord_t x);
    logic [MEM_MASK_W-1:0] kept;
    kept = 16'h000f << {x[1:0], 2'b00};
    return ~kept;
  endfunction

  // each flag full about a quarter of the time
  always @(posedge clk) begin
    if (stall_en) begin
      af_full  <= next_rand_bit() & next_rand_bit();
      wdf_full <= next_rand_bit() & next_rand_bit();
    end else begin
      af_full  <= 1'b0;
      wdf_full <= 1'b0;
    end
  end

  // sees last cycle's enables next to the flags of the cycle before
  always @(posedge clk) begin
    if (!rst) begin
      if (af_wr_en != wdf_wr_en) begin
        $display("ERROR: address and data write enables differ at %0t", $time);
        errors++;
      end
      if ((af_wr_en || wdf_wr_en) && full_seen) begin
        $display("ERROR: write issued in the cycle after a full flag at %0t", $time);
        errors++;
      end
      if (af_wr_en) begin
        got_addr.push_back(af_addr_din);
        got_data.push_back(wdf_din);
        got_mask.push_back(wdf_mask_din);
      end
    end
    full_seen = af_full || wdf_full;
  end

  initial begin
    wait (watchdog_cycles > 0);
    repeat (watchdog_cycles) @(posedge clk);
    $display("ERROR: watchdog expired after %0d cycles, the run did not finish", watchdog_cycles);
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    int n;
    int low_cycles;
    int hold_left;
    int case_errors;
    int total_pixels;
    line_case_t lc;
    pixel_t p;

    load_cases();
    total_pixels = 0;
    for (int i = 0; i < NUM_CASES; i++) begin
      total_pixels += ref_count(line_cases[i]);
    end
    watchdog_cycles = total_pixels * 20 + 200;

    repeat (10) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    check_count("af_wr_en after reset", int'(af_wr_en), 0);
    check_count("wdf_wr_en after reset", int'(wdf_wr_en), 0);
    check_count("cmd_ready after reset", int'(cmd_ready), 1);

    for (int i = 0; i < NUM_CASES; i++) begin
      lc = line_cases[i];
      ref_line(lc);
      n = ref_pixels.size();
      case_errors = errors;
      got_addr.delete();
      got_data.delete();
      got_mask.delete();

      stall_en <= lc.stall;
      cmd <= '{x0: lc.x0, y0: lc.y0, x1: lc.x1, y1: lc.y1, color: lc.color};
      cmd_valid <= 1'b1;
      @(posedge clk);
      while (!cmd_ready) @(posedge clk);

      // long lines keep cmd_valid up into the draw to show it is ignored
      hold_left = (n > 2 * HOLD_CYCLES) ? HOLD_CYCLES : 0;
      if (hold_left == 0) begin
        cmd_valid <= 1'b0;
      end
      low_cycles = 0;
      @(posedge clk);
      while (!cmd_ready) begin
        low_cycles++;
        if (hold_left > 0) begin
          hold_left--;
          if (hold_left == 0) begin
            cmd_valid <= 1'b0;
          end
        end
        @(posedge clk);
      end
      if (!lc.stall) begin
        check_count("cmd_ready low cycles", low_cycles, n + 1);
      end else if (low_cycles < n + 1) begin
        $display("ERROR: cmd_ready rose after %0d cycles, before all pixels were pushed",
                 low_cycles);
        errors++;
      end

      while (got_addr.size() < n) @(negedge clk);
      stall_en <= 1'b0;
      // quiet period to catch repeated or extra writes
      repeat (12) @(posedge clk);

      check_count("write count", got_addr.size(), ref_count(lc));
      for (int k = 0; k < n && k < got_addr.size(); k++) begin
        p = ref_pixels[k];
        // frame base at bit 22, y at bit 12, x at bit 2
        check_addr($sformatf("af_addr_din[%0d]", k), got_addr[k],
                   (MEM_ADDR_W'(FB_BASE) << 22) | (MEM_ADDR_W'(p.y) << 12) |
                   (MEM_ADDR_W'(p.x) << 2));
        check_data(k, got_data[k], {4{p.color}}, got_mask[k], lane_mask(p.x));
      end
      $display("case %0d (%0d,%0d)->(%0d,%0d) stall %0b: %0d writes, %0d errors",
               i, lc.x0, lc.y0, lc.x1, lc.y1, lc.stall, got_addr.size(),
               errors - case_errors);
    end

    $display("%0d cases, %0d checks, %0d errors", NUM_CASES, checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- verilog/line_draw_top.sv
`timescale 1ns/1ps

module line_draw_top import line_gfx_pkg::*; #(
  parameter int                   FIFO_DEPTH = 4,
  parameter logic [FB_BASE_W-1:0] FB_BASE    = 9'h041
) (
  input  logic                  clk,
  input  logic                  rst,
  input  line_cmd_t             cmd,
  input  logic                  cmd_valid,
  output logic                  cmd_ready,
  input  logic                  af_full,
  input  logic                  wdf_full,
  output logic [MEM_ADDR_W-1:0] af_addr_din,
  output logic                  af_wr_en,
  output logic [MEM_DATA_W-1:0] wdf_din,
  output logic [MEM_MASK_W-1:0] wdf_mask_din,
  output logic                  wdf_wr_en
);

  logic   push;
  pixel_t push_pixel;
  logic   credit_return;
  logic   pop;
  logic   pop_valid;
  pixel_t head;

  line_engine #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) line_engine_inst (
    .clk          (clk),
    .rst          (rst),
    .cmd          (cmd),
    .cmd_valid    (cmd_valid),
    .cmd_ready    (cmd_ready),
    .push         (push),
    .push_pixel   (push_pixel),
    .credit_return(credit_return)
  );

  pixel_fifo #(
    .DEPTH (FIFO_DEPTH),
    .item_t(pixel_t)
  ) pixel_fifo_inst (
    .clk          (clk),
    .rst          (rst),
    .push         (push),
    .push_item    (push_pixel),
    .pop          (pop),
    .pop_valid    (pop_valid),
    .head         (head),
    .credit_return(credit_return)
  );

  pixel_writer #(
    .FB_BASE(FB_BASE)
  ) pixel_writer_inst (
    .clk         (clk),
    .rst         (rst),
    .pop_valid   (pop_valid),
    .head        (head),
    .pop         (pop),
    .af_full     (af_full),
    .wdf_full    (wdf_full),
    .af_addr_din (af_addr_din),
    .af_wr_en    (af_wr_en),
    .wdf_din     (wdf_din),
    .wdf_mask_din(wdf_mask_din),
    .wdf_wr_en   (wdf_wr_en)
  );

endmodule

//--- verilog/line_engine.sv
`timescale 1ns/1ps

module line_engine import line_gfx_pkg::*; #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic      clk,
  input  logic      rst,
  input  line_cmd_t cmd,
  input  logic      cmd_valid,
  output logic      cmd_ready,
  output logic      push,
  output pixel_t    push_pixel,
  input  logic      credit_return
);

  localparam int CREDIT_W = $clog2(FIFO_DEPTH + 1);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SETUP,
    ST_DRAW
  } state_t;

  state_t state;
  logic [CREDIT_W-1:0] credit_cnt;

  // latched command
  line_cmd_t cmd_r;

  // setup results, computed from the latched command
  coord_t s_adx;
  coord_t s_ady;
  logic   s_steep;
  coord_t s_a0;
  coord_t s_b0;
  coord_t s_a1;
  coord_t s_b1;

  // draw state, major axis runs upward
  logic              steep_r;
  logic              step_down;
  coord_t            major;
  coord_t            major_end;
  coord_t            minor;
  coord_t            delta_major;
  coord_t            delta_minor;
  logic signed [11:0] err;
  logic signed [11:0] err_sub;

  assign cmd_ready = (state == ST_IDLE);
  assign push = (state == ST_DRAW) && (credit_cnt != '0);

  // un-swap the coordinates for the pushed pixel
  assign push_pixel.x     = steep_r ? minor : major;
  assign push_pixel.y     = steep_r ? major : minor;
  assign push_pixel.color = cmd_r.color;

  always_comb begin
    s_adx = (cmd_r.x1 > cmd_r.x0) ? cmd_r.x1 - cmd_r.x0 : cmd_r.x0 - cmd_r.x1;
    s_ady = (cmd_r.y1 > cmd_r.y0) ? cmd_r.y1 - cmd_r.y0 : cmd_r.y0 - cmd_r.y1;
    s_steep = (s_ady > s_adx);
    s_a0 = s_steep ? cmd_r.y0 : cmd_r.x0;
    s_b0 = s_steep ? cmd_r.x0 : cmd_r.y0;
    s_a1 = s_steep ? cmd_r.y1 : cmd_r.x1;
    s_b1 = s_steep ? cmd_r.x1 : cmd_r.y1;
    // walk from the low end of the major axis
    if (s_a0 > s_a1) begin
      s_a0 = s_steep ? cmd_r.y1 : cmd_r.x1;
      s_b0 = s_steep ? cmd_r.x1 : cmd_r.y1;
      s_a1 = s_steep ? cmd_r.y0 : cmd_r.x0;
      s_b1 = s_steep ? cmd_r.x0 : cmd_r.y0;
    end
  end

  assign err_sub = err - signed'({2'b00, delta_minor});

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: begin
          if (cmd_valid) begin
            state <= ST_SETUP;
          end
        end
        ST_SETUP: begin
          state <= ST_DRAW;
        end
        ST_DRAW: begin
          if (push && (major == major_end)) begin
            state <= ST_IDLE;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == ST_IDLE && cmd_valid) begin
      cmd_r <= cmd;
    end
    if (state == ST_SETUP) begin
      steep_r     <= s_steep;
      major       <= s_a0;
      major_end   <= s_a1;
      minor       <= s_b0;
      delta_major <= s_a1 - s_a0;
      delta_minor <= (s_b1 > s_b0) ? s_b1 - s_b0 : s_b0 - s_b1;
      step_down   <= (s_b0 > s_b1);
      err         <= signed'({3'b000, s_a1[9:1] - s_a0[9:1] - {8'd0, s_a0[0] & ~s_a1[0]}});
    end else if (push && (major != major_end)) begin
      major <= major + 1'b1;
      if (err_sub < 0) begin
        minor <= step_down ? minor - 1'b1 : minor + 1'b1;
        err   <= err_sub + signed'({2'b00, delta_major});
      end else begin
        err <= err_sub;
      end
    end
  end

  // one credit per FIFO slot, spent on push and restored on return
  always_ff @(posedge clk) begin
    if (rst) begin
      credit_cnt <= CREDIT_W'(FIFO_DEPTH);
    end else if (push && !credit_return) begin
      credit_cnt <= credit_cnt - 1'b1;
    end else if (!push && credit_return) begin
      credit_cnt <= credit_cnt + 1'b1;
    end
  end

  // returns from the FIFO never push the count past its depth
  assert property (@(posedge clk) disable iff (rst)
    credit_cnt <= CREDIT_W'(FIFO_DEPTH));

endmodule

//--- verilog/line_gfx_pkg.sv
package line_gfx_pkg;

  // screen coordinate, wide enough for 800 x 600
  typedef logic [9:0] coord_t;

  // pixel color with RGB in the low 24 bits and zeros on top
  typedef logic [31:0] color_t;

  // one line command as taken from the command port
  typedef struct packed {
    coord_t x0;
    coord_t y0;
    coord_t x1;
    coord_t y1;
    color_t color;
  } line_cmd_t;

  // one pixel as held in the pixel FIFO
  typedef struct packed {
    coord_t x;
    coord_t y;
    color_t color;
  } pixel_t;

  // memory controller address FIFO and write data FIFO widths
  localparam int MEM_ADDR_W = 31;
  localparam int MEM_DATA_W = 128;
  localparam int MEM_MASK_W = 16;

  // frame base field at the top of the address word
  localparam int FB_BASE_W = 9;

endpackage

//--- verilog/pixel_fifo.sv
`timescale 1ns/1ps

module pixel_fifo import line_gfx_pkg::*; #(
  parameter int  DEPTH  = 4,
  parameter type item_t = pixel_t
) (
  input  logic  clk,
  input  logic  rst,
  input  logic  push,
  input  item_t push_item,
  input  logic  pop,
  output logic  pop_valid,
  output item_t head,
  output logic  credit_return
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  item_t mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  assign pop_valid = (count != '0);
  assign head = mem[rd_ptr];

  // each freed slot goes straight back to the producer
  assign credit_return = pop;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_item;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (!push && pop) begin
        count <= count - 1'b1;
      end
    end
  end

  // the producer's credits must keep it off a full buffer
  assert property (@(posedge clk) disable iff (rst) push |-> (count != CNT_W'(DEPTH)));

  assert property (@(posedge clk) disable iff (rst) pop |-> (count != '0));

endmodule

//--- verilog/pixel_writer.sv
`timescale 1ns/1ps

module pixel_writer import line_gfx_pkg::*; #(
  parameter logic [FB_BASE_W-1:0] FB_BASE = 9'h041
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  pop_valid,
  input  pixel_t                head,
  output logic                  pop,
  input  logic                  af_full,
  input  logic                  wdf_full,
  output logic [MEM_ADDR_W-1:0] af_addr_din,
  output logic                  af_wr_en,
  output logic [MEM_DATA_W-1:0] wdf_din,
  output logic [MEM_MASK_W-1:0] wdf_mask_din,
  output logic                  wdf_wr_en
);

  logic [MEM_ADDR_W-1:0] addr_next;
  logic [MEM_DATA_W-1:0] data_next;
  logic [MEM_MASK_W-1:0] mask_next;

  // both controller FIFOs need room for the single-beat write
  assign pop = pop_valid && !af_full && !wdf_full;

  assign addr_next = {FB_BASE, head.y, head.x, 2'b00};
  assign data_next = {4{head.color}};

  // a set mask bit means the byte is left untouched
  always_comb begin
    mask_next = '1;
    for (int i = 0; i < 4; i++) begin
      if (head.x[1:0] == 2'(i)) begin
        mask_next[4*i +: 4] = 4'b0000;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      af_wr_en  <= 1'b0;
      wdf_wr_en <= 1'b0;
    end else begin
      af_wr_en  <= pop;
      wdf_wr_en <= pop;
    end
  end

  // address, data and mask of the popped pixel
  always_ff @(posedge clk) begin
    if (pop) begin
      af_addr_din  <= addr_next;
      wdf_din      <= data_next;
      wdf_mask_din <= mask_next;
    end
  end

  // a full flag seen in one cycle must block the next cycle's write
  assert property (@(posedge clk) disable iff (rst)
    (af_full || wdf_full) |=> (!af_wr_en && !wdf_wr_en));

endmodule
